// ==== bench/fpAddSubTb.sv ====
`timescale 1ns/1ps

module fpAddSubTb;
	import fpFormatPkg::*;

	localparam int sweepCount = 64;               // Random commutativity pairs
	localparam logic [1:0] kindTable = 2'd0;      // Result known from the table
	localparam logic [1:0] kindFirst = 2'd1;      // a plus b, kept for the partner
	localparam logic [1:0] kindSecond = 2'd2;     // b plus a, must match the first

	// One table row
	typedef struct packed {
		fp16WordT a;
		fp16WordT b;
		logic opSub;
		fp16WordT expected;
	} vecT;

	// What the next outValid should carry
	typedef struct packed {
		logic [1:0] kind;
		fp16WordT word;
	} expectT;

	logic clk;
	logic rstN;
	logic inValid;
	logic opSub;
	fp16WordT a;
	fp16WordT b;
	logic outValid;
	fp16WordT result;

	vecT vecTable[$];
	expectT expQ[$];                              // In flight, oldest first
	expectT head;
	fp16WordT pairFirst;                          // First half of a sweep pair
	int issued;
	int received;
	int cycleCount;
	int seed;
	logic [31:0] randWord;

	fpAddSub fpAddSub_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.opSub(opSub),
		.a(a),
		.b(b),
		.outValid(outValid),
		.result(result)
	);

	always #4 clk = ~clk;                         // 8 ns period

	task abortRun();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task checkWord(input fp16WordT want, input fp16WordT got, input int opIndex);
		if (got !== want) begin
			$display("error: result expected %h actual %h at operation %0d", want, got, opIndex);
			abortRun();
		end
	endtask

	// Every pulse in gives exactly one pulse out
	task checkStrobe(input int sent, input int seen);
		if (sent != seen) begin
			$display("outValid count is wrong, %0d operations issued but %0d results seen",
				sent, seen);
			abortRun();
		end
	endtask

	task addVector(input fp16WordT opA, input fp16WordT opB, input logic sub,
		input fp16WordT want);
		vecTable.push_back('{opA, opB, sub, want});
	endtask

	task expectOp(input logic [1:0] kind, input fp16WordT want);
		expQ.push_back('{kind, want});
		issued = issued + 1;
	endtask

	// Expected words worked out by hand, RNE with flush to zero
	task loadTable();
		addVector(16'h3C00, 16'h3C00, 1'b0, 16'h4000);   // 1 + 1
		addVector(16'h4000, 16'h3C00, 1'b0, 16'h4200);   // Shift 1
		addVector(16'h4200, 16'h3C00, 1'b1, 16'h4000);   // 3 - 1
		addVector(16'h4800, 16'h3C00, 1'b0, 16'h4880);   // Shift 3
		addVector(16'h5800, 16'h3C00, 1'b0, 16'h5808);   // Shift 7
		addVector(16'h3C00, 16'h1400, 1'b0, 16'h3C01);   // Shift 10 lands on the LSB
		addVector(16'h4800, 16'h3C00, 1'b1, 16'h4700);   // 8 - 1 renormalizes left
		addVector(16'h4800, 16'hBC00, 1'b0, 16'h4700);   // Mixed signs
		addVector(16'h3C00, 16'h4000, 1'b1, 16'hBC00);   // B larger, sign from B
		addVector(16'h3C00, 16'hBC00, 1'b1, 16'h4000);
		addVector(16'hBC00, 16'hBC00, 1'b0, 16'hC000);
		addVector(16'h3E00, 16'h3E00, 1'b0, 16'h4200);   // Carry out of the add
		addVector(16'h3C00, 16'h0800, 1'b0, 16'h3C00);   // Shift 13
		addVector(16'h3C01, 16'h3C00, 1'b1, 16'h1400);   // Deep cancellation
		// Rounding
		addVector(16'h3C00, 16'h1000, 1'b0, 16'h3C00);   // Tie, stays even
		addVector(16'h3C01, 16'h1000, 1'b0, 16'h3C02);   // Tie, odd rounds up
		addVector(16'h3C00, 16'h1001, 1'b0, 16'h3C01);   // Sticky above the tie
		addVector(16'h3C00, 16'h0C00, 1'b0, 16'h3C00);   // Below the tie
		addVector(16'h3FFF, 16'h1000, 1'b0, 16'h4000);   // Carry into the exponent
		addVector(16'h3C00, 16'h0400, 1'b0, 16'h3C00);   // Shift 14, sticky only
		addVector(16'h3C00, 16'h0400, 1'b1, 16'h3C00);   // Borrow from sticky rounds back
		addVector(16'h3C00, 16'h1000, 1'b1, 16'h3BFF);
		// Zeros and subnormals
		addVector(16'h3C00, 16'h3C00, 1'b1, 16'h0000);   // Cancellation is +0
		addVector(16'hBC00, 16'hBC00, 1'b1, 16'h0000);
		addVector(16'h8000, 16'h0000, 1'b1, 16'h8000);   // -0 - +0
		addVector(16'h8000, 16'h8000, 1'b0, 16'h8000);
		addVector(16'h0000, 16'h8000, 1'b0, 16'h0000);
		addVector(16'h0001, 16'h3C00, 1'b0, 16'h3C00);   // Subnormal acts as zero
		addVector(16'h8200, 16'h0000, 1'b0, 16'h0000);
		addVector(16'h8001, 16'h8000, 1'b0, 16'h8000);   // Flushed to -0
		addVector(16'h0401, 16'h0400, 1'b1, 16'h0000);   // Underflow flush
		addVector(16'h0800, 16'h0400, 1'b1, 16'h0400);   // Smallest normal survives
		// Overflow and specials
		addVector(16'h7BFF, 16'h7BFF, 1'b0, 16'h7C00);
		addVector(16'hFBFF, 16'hFBFF, 1'b0, 16'hFC00);
		addVector(16'h7BFF, 16'h4C00, 1'b0, 16'h7C00);   // Rounding carry overflows
		addVector(16'h7E00, 16'h3C00, 1'b0, 16'h7E00);
		addVector(16'h7C01, 16'h3C00, 1'b0, 16'h7E00);   // Signaling payload dropped
		addVector(16'h3C00, 16'hFE00, 1'b1, 16'h7E00);
		addVector(16'h7C00, 16'h7C00, 1'b1, 16'h7E00);   // Inf - Inf
		addVector(16'h7C00, 16'hFC00, 1'b0, 16'h7E00);
		addVector(16'h7C00, 16'h7C00, 1'b0, 16'h7C00);
		addVector(16'h7C00, 16'h3C00, 1'b0, 16'h7C00);
		addVector(16'h3C00, 16'h7C00, 1'b1, 16'hFC00);   // Flipped infinity passes
		addVector(16'hFC00, 16'h4000, 1'b0, 16'hFC00);
	endtask

	// Stimulus
	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		opSub = 1'b0;
		a = '0;
		b = '0;
		issued = 0;
		received = 0;
		cycleCount = 0;
		seed = 97315;
		loadTable();
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		foreach (vecTable[i]) begin
			@(posedge clk);                       // Back to back, one per cycle
			inValid <= 1'b1;
			opSub <= vecTable[i].opSub;
			a <= vecTable[i].a;
			b <= vecTable[i].b;
			expectOp(kindTable, vecTable[i].expected);
		end
		for (int n = 0; n < sweepCount; n++) begin
			randWord = $random(seed);
			@(posedge clk);
			opSub <= 1'b0;
			a <= randWord[15:0];
			b <= randWord[31:16];
			expectOp(kindFirst, '0);
			@(posedge clk);                       // Same pair swapped
			a <= randWord[31:16];
			b <= randWord[15:0];
			expectOp(kindSecond, '0);
		end
		@(posedge clk);
		inValid <= 1'b0;
		// Last result is due three edges after its strobe, plus margin for stray pulses
		repeat (5) @(posedge clk);
		checkStrobe(issued, received);
		if (expQ.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("%0d expected results were never matched", expQ.size());
			abortRun();
		end
	end

	// Results are stable away from the rising edge
	always @(negedge clk) begin
		if (rstN && outValid) begin
			received = received + 1;
			if (expQ.size() == 0) begin
				checkStrobe(issued, received);    // More results than operations
			end else begin
				head = expQ.pop_front();
				if (head.kind == kindTable) begin
					checkWord(head.word, result, received - 1);
				end else if (head.kind == kindFirst) begin
					pairFirst = result;
				end else begin
					checkWord(pairFirst, result, received - 1); // a + b against b + a
				end
			end
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > vecTable.size() + 2 * sweepCount + 20) begin
			$display("timeout after %0d cycles, %0d of %0d results received",
				cycleCount, received, issued);
			abortRun();
		end
	end
endmodule

// ==== bench/fpAddSub_chk.sv ====
`timescale 1ns/1ps

module fpAddSubChk (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic outValid,
	input fpFormatPkg::fp16WordT result
);
	import fpFormatPkg::*;

	localparam int latency = 3;                   // Front register plus two normalize stages

	// One pulse out for each pulse in, three edges later
	strobeDelay: assert property (@(posedge clk) disable iff (!rstN)
		outValid == $past(inValid, latency))
		else $error("outValid does not follow inValid by three cycles");

	resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
		else $error("outValid high during reset");

	// Magnitude above infinity means a NaN encoding
	canonNan: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && (result.raw.mag > {expWidth'(expMax), manWidth'(0)}))
		|-> (result == qNan))
		else $error("result is a NaN other than 7E00");
endmodule

bind fpAddSub fpAddSubChk fpAddSubChk_inst (
	.clk(clk),
	.rstN(rstN),
	.inValid(inValid),
	.outValid(outValid),
	.result(result)
);

// ==== flist.f ====
hdl/fpFormatPkg.sv
hdl/fpPipePkg.sv
hdl/fpShiftDetect.sv
hdl/fpAlignModule.sv
hdl/fpExceptionDetect.sv
hdl/fpNormRound.sv
hdl/fpAddSub.sv
bench/fpAddSub_chk.sv
bench/fpAddSubTb.sv

// ==== hdl/fpAddSub.sv ====
`timescale 1ns/1ps

module fpAddSub (
	input logic clk,
	input logic rstN,
	input logic inValid,                          // Operand pair strobe
	input logic opSub,                            // 1 for a minus b
	input fpFormatPkg::fp16WordT a,
	input fpFormatPkg::fp16WordT b,
	output logic outValid,                        // Three cycles after inValid
	output fpFormatPkg::fp16WordT result
);
	import fpPipePkg::*;

	shiftDetT det;                                // Front stage register output
	alignT align;                                 // Combinational align result
	excT exc;                                     // Combinational special case result

	// Stage 1, operand capture and exponent differences
	fpShiftDetect fpShiftDetect_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.opSub(opSub),
		.a(a),
		.b(b),
		.det(det)
	);

	// Align and exception decode work side by side on the same record
	fpAlignModule fpAlignModule_inst (
		.det(det),
		.align(align)
	);

	fpExceptionDetect fpExceptionDetect_inst (
		.det(det),
		.exc(exc)
	);

	// Stages 2 and 3, add, normalize and round
	fpNormRound fpNormRound_inst (
		.clk(clk),
		.rstN(rstN),
		.align(align),
		.exc(exc),
		.valid(det.valid),                        // Strobe rides with the record
		.outValid(outValid),
		.result(result)
	);
endmodule

// ==== hdl/fpAlignModule.sv ====
`timescale 1ns/1ps

module fpAlignModule (
	input fpPipePkg::shiftDetT det,
	output fpPipePkg::alignT align
);
	import fpFormatPkg::*;

	logic maxAB;                                  // B has the larger magnitude
	logic [expWidth-1:0] shiftA;                  // A larger, so B shifts by A minus B
	logic [expWidth-1:0] shiftB;

	// Raw view compares exponent and fraction in one step
	assign maxAB = det.a.raw.mag < det.b.raw.mag; // Ties keep A

	assign shiftA = det.shiftDet[expWidth-1:0];
	assign shiftB = det.shiftDet[2*expWidth-1:expWidth];

	always_comb begin
		align.maxAB = maxAB;
		// Exponent of the larger operand becomes the common one
		align.cExp = maxAB ? det.b.fields.exp : det.a.fields.exp;
		align.shift = maxAB ? shiftB : shiftA;    // Only the positive difference is used
		// Smaller mantissa, shifted later
		align.mMin = maxAB ? det.a.fields.man : det.b.fields.man;
		align.mMax = maxAB ? det.b.fields.man : det.a.fields.man;
		align.sign = maxAB ? det.signB : det.signA; // Result follows the larger operand
		align.effSub = det.effSub;
	end
endmodule

// ==== hdl/fpExceptionDetect.sv ====
`timescale 1ns/1ps

module fpExceptionDetect (
	input fpPipePkg::shiftDetT det,
	output fpPipePkg::excT exc
);
	import fpFormatPkg::*;

	logic aTop;                                   // Exponent all ones
	logic bTop;
	logic aNan;
	logic bNan;
	logic aInf;
	logic bInf;
	logic aZero;                                  // Includes flushed subnormals
	logic bZero;

	assign aTop = det.a.fields.exp == expWidth'(expMax);
	assign bTop = det.b.fields.exp == expWidth'(expMax);
	assign aNan = aTop && (det.a.fields.man != '0);
	assign bNan = bTop && (det.b.fields.man != '0);
	assign aInf = aTop && (det.a.fields.man == '0);
	assign bInf = bTop && (det.b.fields.man == '0);
	assign aZero = det.a.fields.exp == '0;        // Mantissa already cleared upstream
	assign bZero = det.b.fields.exp == '0;

	always_comb begin
		exc.isSpecial = 1'b0;
		exc.specialWord = '0;
		// Inf minus Inf has no value
		if (aNan || bNan || (aInf && bInf && det.effSub)) begin
			exc.isSpecial = 1'b1;
			exc.specialWord = qNan;               // Input payloads are dropped
		end else if (aInf || bInf) begin
			// Same sign infinities or a single one, the infinity passes
			exc.isSpecial = 1'b1;
			exc.specialWord.fields.sign = aInf ? det.signA : det.signB;
			exc.specialWord.fields.exp = expWidth'(expMax);
			exc.specialWord.fields.man = '0;
		end
		exc.bothZero = aZero && bZero;
		// Zero sum is negative only for -0 plus -0
		exc.zeroSign = det.signA && det.signB;
	end
endmodule

// ==== hdl/fpFormatPkg.sv ====
package fpFormatPkg;

	// IEEE 754 binary16 field widths
	localparam int expWidth = 5;
	localparam int manWidth = 10;

	localparam int expBias = 15;                  // Exponent bias
	localparam int expMax = 31;                   // All-ones exponent, Inf or NaN

	// Canonical quiet NaN, sign clear and top mantissa bit set
	localparam logic [expWidth+manWidth:0] qNan = 16'h7E00;

	// Field view of one half-precision word
	typedef struct packed {
		logic sign;
		logic [expWidth-1:0] exp;                 // Biased exponent
		logic [manWidth-1:0] man;                 // Fraction without hidden bit
	} fp16FieldsT;

	// Sign and magnitude view, used for the ordering compare
	typedef struct packed {
		logic sign;
		logic [expWidth+manWidth-1:0] mag;        // Exponent and fraction as one number
	} fp16RawT;

	// The same 16 bits seen two ways
	// The magnitude orders like the value because the exponent sits above the fraction
	typedef union packed {
		fp16FieldsT fields;
		fp16RawT raw;
	} fp16WordT;

endpackage

// ==== hdl/fpNormRound.sv ====
`timescale 1ns/1ps

module fpNormRound (
	input logic clk,
	input logic rstN,
	input fpPipePkg::alignT align,
	input fpPipePkg::excT exc,
	input logic valid,
	output logic outValid,
	output fpFormatPkg::fp16WordT result
);
	import fpFormatPkg::*;
	import fpPipePkg::*;

	typedef logic signed [expWidth+1:0] expST;    // Room for borrow and carry

	logic hidMax;                                 // Hidden bits
	logic hidMin;
	logic [sigWidth-1:0] sigMax;                  // Hidden, fraction, guard, round, sticky
	logic [sigWidth-1:0] sigMin;
	logic [sigWidth-1:0] sigMinSh;                // Smaller significand after alignment
	logic [sigWidth-1:0] lostMask;                // Bits pushed out by the shift
	logic [sigWidth:0] sumD;                      // Carry bit on top

	// First register
	logic validQ;
	logic [sigWidth:0] sumQ;
	logic [expWidth-1:0] cExpQ;
	logic signQ;
	excT excQ;

	// Second stage
	int lead;                                     // Position of the leading one
	logic [sigWidth-1:0] norm;
	expST expAdj;                                 // Exponent change from normalizing
	logic roundUp;
	logic [manWidth+1:0] rnd;                     // Rounded significand with carry out
	expST expUnb;                                 // Unbiased result exponent
	fp16WordT resD;

	assign hidMax = align.cExp != '0;             // Zero exponent only for zero after flush
	// The smaller exponent is cExp minus shift, so it is zero exactly here
	assign hidMin = align.cExp != align.shift;
	assign sigMax = {hidMax, align.mMax, guardBits'(0)};
	assign sigMin = {hidMin, align.mMin, guardBits'(0)};

	always_comb begin
		lostMask = '1;                            // Shift past the width, all is sticky
		sigMinSh = '0;
		if (align.shift < expWidth'(sigWidth)) begin
			lostMask = (sigWidth'(1) << align.shift) - sigWidth'(1);
			sigMinSh = sigMin >> align.shift;
		end
		sigMinSh[0] = sigMinSh[0] | (|(sigMin & lostMask)); // Sticky collect
		// Larger minus smaller never goes negative
		if (align.effSub) begin
			sumD = {1'b0, sigMax} - {1'b0, sigMinSh};
		end else begin
			sumD = {1'b0, sigMax} + {1'b0, sigMinSh};
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= valid;
		end
	end

	always_ff @(posedge clk) begin
		sumQ <= sumD;
		cExpQ <= align.cExp;
		signQ <= align.sign;
		excQ <= exc;
	end

	always_comb begin
		lead = 0;
		for (int i = 0; i <= sigWidth; i++) begin
			if (sumQ[i]) begin
				lead = i;
			end
		end
		if (sumQ[sigWidth]) begin
			// Carry out of the add, one step right
			norm = sumQ[sigWidth:1];
			norm[0] = sumQ[1] | sumQ[0];          // Dropped bit joins sticky
			expAdj = expST'(1);
		end else begin
			// Cancellation, leading one moves up to the hidden position
			norm = sumQ[sigWidth-1:0] << (sigWidth - 1 - lead);
			expAdj = expST'(lead - (sigWidth - 1));
		end
		// Nearest even, ties go to an even LSB
		roundUp = norm[guardBits-1] & ((|norm[guardBits-2:0]) | norm[guardBits]);
		rnd = {1'b0, norm[sigWidth-1:guardBits]} + {{(manWidth+1){1'b0}}, roundUp};
		// Rounding carry bumps the exponent
		expUnb = expST'(cExpQ) - expST'(expBias) + expAdj + expST'(rnd[manWidth+1]);

		resD.fields.sign = signQ;
		resD.fields.exp = expWidth'(expUnb + expST'(expBias));
		resD.fields.man = rnd[manWidth+1] ? rnd[manWidth:1] : rnd[manWidth-1:0];
		if (excQ.isSpecial) begin
			resD = excQ.specialWord;              // NaN or infinity wins
		end else if ((sumQ == '0) || (expUnb < expST'(1 - expBias))) begin
			resD = '0;                            // Cancellation or underflow flush
			resD.fields.sign = excQ.bothZero & excQ.zeroSign;
		end else if (expUnb > expST'(expMax - 1 - expBias)) begin
			resD.fields.exp = expWidth'(expMax);  // Overflow to signed infinity
			resD.fields.man = '0;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			result <= '0;
		end else begin
			outValid <= validQ;
			result <= resD;
		end
	end
endmodule

// ==== hdl/fpPipePkg.sv ====
package fpPipePkg;

	// Guard, round and sticky bits below the mantissa
	localparam int guardBits = 3;

	// Hidden bit, fraction and guard bits
	localparam int sigWidth = fpFormatPkg::manWidth + 1 + guardBits;

	// Front stage output record
	typedef struct packed {
		fpFormatPkg::fp16WordT a;                 // Operands after the subnormal flush
		fpFormatPkg::fp16WordT b;
		logic [2*fpFormatPkg::expWidth-1:0] shiftDet; // B minus A high, A minus B low
		logic signA;                              // Result sign if A is larger
		logic signB;                              // Result sign if B is larger, opSub applied
		logic effSub;                             // Signs differ after the flip
		logic valid;
	} shiftDetT;

	// Alignment decision
	typedef struct packed {
		logic [fpFormatPkg::expWidth-1:0] cExp;   // Common exponent
		logic maxAB;                              // 1 when B is larger
		logic [fpFormatPkg::expWidth-1:0] shift;  // Right shift for the smaller mantissa
		logic [fpFormatPkg::manWidth-1:0] mMin;
		logic [fpFormatPkg::manWidth-1:0] mMax;
		logic sign;                               // Sign of the larger operand
		logic effSub;
	} alignT;

	// Special operand result
	typedef struct packed {
		logic isSpecial;                          // specialWord replaces the sum
		fpFormatPkg::fp16WordT specialWord;
		logic bothZero;
		logic zeroSign;                           // Sign for a zero plus zero
	} excT;

endpackage

// ==== hdl/fpShiftDetect.sv ====
`timescale 1ns/1ps

module fpShiftDetect (
	input logic clk,
	input logic rstN,
	input logic inValid,                          // One operand pair this cycle
	input logic opSub,                            // Compute a minus b
	input fpFormatPkg::fp16WordT a,
	input fpFormatPkg::fp16WordT b,
	output fpPipePkg::shiftDetT det               // Registered front stage record
);
	import fpFormatPkg::*;
	import fpPipePkg::*;

	fp16WordT aFlush;                             // Operands with subnormals flushed
	fp16WordT bFlush;
	logic signB;                                  // Effective sign of b
	shiftDetT detD;                               // Record before the register
	shiftDetT detQ;
	logic validQ;

	// A zero exponent means zero or subnormal, both become signed zero
	always_comb begin
		aFlush = a;
		bFlush = b;
		if (a.fields.exp == '0) begin
			aFlush.fields.man = '0;
		end
		if (b.fields.exp == '0) begin
			bFlush.fields.man = '0;
		end
	end

	assign signB = b.fields.sign ^ opSub;         // Subtract is add with b negated

	always_comb begin
		detD.a = aFlush;
		detD.b = bFlush;
		// Both differences, the align block keeps the one for the larger operand
		detD.shiftDet[expWidth-1:0] = aFlush.fields.exp - bFlush.fields.exp;
		detD.shiftDet[2*expWidth-1:expWidth] = bFlush.fields.exp - aFlush.fields.exp;
		detD.signA = aFlush.fields.sign;
		detD.signB = signB;
		detD.effSub = aFlush.fields.sign ^ signB; // Magnitudes get subtracted
		detD.valid = inValid;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		detQ <= detD;                             // Operand payload
	end

	always_comb begin
		det = detQ;
		det.valid = validQ;                       // Strobe from the reset flop
	end
endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the fp16 adder testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -j 0 --top-module fpAddSubTb -f flist.f -o fpAddSubSim \
	&& ./obj_dir/fpAddSubSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a pass line"; exit 1; }
echo "Simulation passed"
